//--- source/adder_pkg.sv
// Struct fields are sized by DATA_WIDTH and SLICE_WIDTH_DEFAULT, so the unit is built for one 64-bit word in two 32-bit halves
package adder_pkg;

	// One operand word, split into two equal slices
	localparam int DATA_WIDTH = 64;
	localparam int SLICE_WIDTH_DEFAULT = 32;

	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [SLICE_WIDTH_DEFAULT-1:0] slice_t;

	// Registered operands, b already inverted for subtraction
	typedef struct packed {
		word_t a;
		word_t b_eff;
		logic carry_in;
		logic valid;
	} operands_t;

	// Both carry-select candidates of one slice
	typedef struct packed {
		slice_t sum0;
		slice_t sum1;
		logic cout0;
		logic cout1;
		logic msb_cin0;
		logic msb_cin1;
	} slice_result_t;

	typedef struct packed {
		word_t sum;
		logic carry;
		logic overflow;
		logic zero;
		logic negative;
	} result_t;

	// Black cell, returns {group generate, group propagate}
	function automatic logic [1:0] gp_black(
		input logic g_hi,
		input logic p_hi,
		input logic g_lo,
		input logic p_lo
	);
		return {g_hi | (p_hi & g_lo), p_hi & p_lo};
	endfunction

	// Grey cell, generate only
	function automatic logic gp_grey(
		input logic g_hi,
		input logic p_hi,
		input logic g_lo
	);
		return g_hi | (p_hi & g_lo);
	endfunction

endpackage

//--- source/operand_stage.sv
// WIDTH must equal the package word width; operands are taken only on cycles with in_valid high
module operand_stage #(
	parameter int WIDTH = adder_pkg::DATA_WIDTH
) (
	input  logic clk,
	input  logic rst,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic sub,
	input  logic in_valid,
	output adder_pkg::operands_t ops
);

	logic [WIDTH-1:0] b_sel;

	if (WIDTH != $bits(adder_pkg::word_t)) begin : g_width_check
		$error("operand_stage: WIDTH does not match the package word");
	end

	// a - b is a + ~b + 1
	assign b_sel = sub ? ~b : b;

	always_ff @(posedge clk) begin
		// Data fields hold their last value between operations
		if (in_valid) begin
			ops.a <= a;
			ops.b_eff <= b_sel;
			ops.carry_in <= sub;
		end
		if (rst) begin
			ops.valid <= 1'b0;
		end else begin
			ops.valid <= in_valid;
		end
	end

	// The mode bit must be defined whenever an operation is offered
	sub_known_a: assert property (
		@(posedge clk) disable iff (rst)
		in_valid |-> !$isunknown(sub)
	) else $error("operand_stage: sub unknown with in_valid high");

endmodule

//--- source/prefix_tree.sv
// SLICE_WIDTH must be a power of two, at least 4; returns group terms from each bit down to bit 0
module prefix_tree #(
	parameter int SLICE_WIDTH = adder_pkg::SLICE_WIDTH_DEFAULT
) (
	input  logic [SLICE_WIDTH-1:0] g_in,
	input  logic [SLICE_WIDTH-1:0] p_in,
	output logic [SLICE_WIDTH-1:0] g_pre,
	output logic [SLICE_WIDTH-1:0] p_pre
);

	import adder_pkg::*;

	localparam int LEVELS = $clog2(SLICE_WIDTH);

	// Level 0 holds the raw bit terms, level l+1 the output of black level l
	logic [SLICE_WIDTH-1:0] g_lvl [LEVELS+1];
	logic [SLICE_WIDTH-1:0] p_lvl [LEVELS+1];

	if (((1 << LEVELS) != SLICE_WIDTH) || (SLICE_WIDTH < 4)) begin : g_width_check
		$error("prefix_tree: SLICE_WIDTH must be a power of two of at least 4");
	end

	assign g_lvl[0] = g_in;
	assign p_lvl[0] = p_in;

	// Sparse black levels
	// Only odd positions combine; at level l an odd bit i reaches back 2**l bits,
	// so after the last level every odd bit spans down to bit 0
	for (genvar l = 0; l < LEVELS; l++) begin : g_level
		for (genvar i = 0; i < SLICE_WIDTH; i++) begin : g_bit
			localparam int LO = i - (1 << l);

			if ((i % 2 == 1) && (LO >= 0)) begin : g_black
				assign {g_lvl[l+1][i], p_lvl[l+1][i]} = gp_black(
					g_lvl[l][i],
					p_lvl[l][i],
					g_lvl[l][LO],
					p_lvl[l][LO]
				);
			end else begin : g_pass
				// Even bits, and odd bits already anchored at bit 0
				assign g_lvl[l+1][i] = g_lvl[l][i];
				assign p_lvl[l+1][i] = p_lvl[l][i];
			end
		end
	end

	// Final grey level
	// Each even bit folds its own term onto the odd neighbour below it
	for (genvar i = 0; i < SLICE_WIDTH; i++) begin : g_out
		if (i == 0) begin : g_bit0
			assign g_pre[i] = g_in[i];
			assign p_pre[i] = p_in[i];
		end else if (i % 2 == 1) begin : g_odd
			assign g_pre[i] = g_lvl[LEVELS][i];
			assign p_pre[i] = p_lvl[LEVELS][i];
		end else begin : g_even
			assign g_pre[i] = gp_grey(g_in[i], p_in[i], g_lvl[LEVELS][i-1]);
			// Group propagate for the carry-in-one sum
			assign p_pre[i] = p_in[i] & p_lvl[LEVELS][i-1];
		end
	end

endmodule

//--- source/prefix_adder_slice.sv
// Purely combinational; SLICE_WIDTH must equal the package slice width
module prefix_adder_slice #(
	parameter int SLICE_WIDTH = adder_pkg::SLICE_WIDTH_DEFAULT
) (
	input  logic [SLICE_WIDTH-1:0] a,
	input  logic [SLICE_WIDTH-1:0] b,
	output adder_pkg::slice_result_t res
);

	import adder_pkg::*;

	logic [SLICE_WIDTH-1:0] g;
	logic [SLICE_WIDTH-1:0] p;
	logic [SLICE_WIDTH-1:0] g_pre;
	logic [SLICE_WIDTH-1:0] p_pre;
	// Carry into each bit, plus the carry out at the top
	logic [SLICE_WIDTH:0] c0;
	logic [SLICE_WIDTH:0] c1;

	if (SLICE_WIDTH != $bits(slice_t)) begin : g_width_check
		$error("prefix_adder_slice: SLICE_WIDTH does not match the package slice");
	end

	// Pre-computation
	assign g = a & b;
	assign p = a ^ b;

	prefix_tree #(
		.SLICE_WIDTH(SLICE_WIDTH)
	) u_tree (
		.g_in(g),
		.p_in(p),
		.g_pre(g_pre),
		.p_pre(p_pre)
	);

	// Carry-in of zero, the group generate alone
	assign c0 = {g_pre, 1'b0};

	// Carry-in of one passes through any fully propagating group
	assign c1[0] = 1'b1;
	for (genvar i = 0; i < SLICE_WIDTH; i++) begin : g_c1
		assign c1[i+1] = gp_grey(g_pre[i], p_pre[i], 1'b1);
	end

	// Post-computation for both candidates
	assign res.sum0 = p ^ c0[SLICE_WIDTH-1:0];
	assign res.sum1 = p ^ c1[SLICE_WIDTH-1:0];
	assign res.cout0 = c0[SLICE_WIDTH];
	assign res.cout1 = c1[SLICE_WIDTH];
	assign res.msb_cin0 = c0[SLICE_WIDTH-1];
	assign res.msb_cin1 = c1[SLICE_WIDTH-1];

endmodule

//--- source/result_combine.sv
// WIDTH must be two package slices wide; result holds its last value while no operation arrives
module result_combine #(
	parameter int WIDTH = adder_pkg::DATA_WIDTH
) (
	input  logic clk,
	input  logic rst,
	input  adder_pkg::operands_t ops,
	input  adder_pkg::slice_result_t lo,
	input  adder_pkg::slice_result_t hi,
	output adder_pkg::result_t result,
	output logic out_valid
);

	import adder_pkg::*;

	slice_t lo_sum;
	slice_t hi_sum;
	logic lo_cout;
	logic hi_cout;
	logic hi_msb_cin;
	logic [WIDTH-1:0] sum;
	result_t result_next;

	if (WIDTH != 2 * $bits(slice_t) || WIDTH != $bits(word_t)) begin : g_width_check
		$error("result_combine: WIDTH must be one word of two slices");
	end

	// Low half is picked by the unit's carry-in
	assign lo_sum = ops.carry_in ? lo.sum1 : lo.sum0;
	assign lo_cout = ops.carry_in ? lo.cout1 : lo.cout0;

	// High half is picked by the low half's carry out
	assign hi_sum = lo_cout ? hi.sum1 : hi.sum0;
	assign hi_cout = lo_cout ? hi.cout1 : hi.cout0;
	assign hi_msb_cin = lo_cout ? hi.msb_cin1 : hi.msb_cin0;

	assign sum = {hi_sum, lo_sum};

	// Flags
	// Carry is the plain carry out, so a subtraction without borrow sets it
	assign result_next.sum = sum;
	assign result_next.carry = hi_cout;
	assign result_next.overflow = hi_cout ^ hi_msb_cin;
	assign result_next.zero = (sum == '0);
	assign result_next.negative = sum[WIDTH-1];

	always_ff @(posedge clk) begin
		if (ops.valid) begin
			result <= result_next;
		end
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= ops.valid;
		end
	end

	out_valid_known_a: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown(out_valid)
	) else $error("result_combine: out_valid unknown");

	// One result strobe per registered operation, one cycle later
	out_valid_follow_a: assert property (
		@(posedge clk) disable iff (rst)
		out_valid == ($past(ops.valid) && !$past(rst))
	) else $error("result_combine: out_valid does not follow the operand valid");

endmodule

//--- source/add_unit_top.sv
// Two-cycle add/subtract unit without back-pressure; WIDTH must be twice SLICE_WIDTH
module add_unit_top #(
	parameter int WIDTH = adder_pkg::DATA_WIDTH,
	parameter int SLICE_WIDTH = adder_pkg::SLICE_WIDTH_DEFAULT
) (
	input  logic clk,
	input  logic rst,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic sub,
	input  logic in_valid,
	output adder_pkg::result_t result,
	output logic out_valid
);

	import adder_pkg::*;

	operands_t ops;
	slice_result_t res_lo;
	slice_result_t res_hi;

	operand_stage #(
		.WIDTH(WIDTH)
	) u_operand_stage (
		.clk(clk),
		.rst(rst),
		.a(a),
		.b(b),
		.sub(sub),
		.in_valid(in_valid),
		.ops(ops)
	);

	// Both halves run side by side on the registered operands
	prefix_adder_slice #(
		.SLICE_WIDTH(SLICE_WIDTH)
	) slice_lo (
		.a(ops.a[SLICE_WIDTH-1:0]),
		.b(ops.b_eff[SLICE_WIDTH-1:0]),
		.res(res_lo)
	);

	prefix_adder_slice #(
		.SLICE_WIDTH(SLICE_WIDTH)
	) slice_hi (
		.a(ops.a[WIDTH-1:SLICE_WIDTH]),
		.b(ops.b_eff[WIDTH-1:SLICE_WIDTH]),
		.res(res_hi)
	);

	result_combine #(
		.WIDTH(WIDTH)
	) u_result_combine (
		.clk(clk),
		.rst(rst),
		.ops(ops),
		.lo(res_lo),
		.hi(res_hi),
		.result(result),
		.out_valid(out_valid)
	);

endmodule

//--- sim/add_unit_checker.sv
// Expects each result one rising edge after the edge that captured its operation; outputs are sampled on the falling edge
module add_unit_checker (
	input  logic clk,
	input  logic rst,
	input  adder_pkg::word_t a,
	input  adder_pkg::word_t b,
	input  logic sub,
	input  logic in_valid,
	input  adder_pkg::result_t result,
	input  logic out_valid,
	output int pushed,
	output int popped,
	output int errors
);

	import adder_pkg::*;

	// Operand register at the capturing edge, result register at the next
	localparam int DUE_CYCLES = 1;

	typedef struct packed {
		result_t res;
		int cycle;
	} expect_t;

	expect_t exp_q[$];
	expect_t item;
	int cycle = 0;
	int n_pushed = 0;
	int n_popped = 0;
	int n_errors = 0;

	assign pushed = n_pushed;
	assign popped = n_popped;
	assign errors = n_errors;

	// Expected result from 65-bit arithmetic on the raw operands
	function automatic result_t ref_add(input word_t x, input word_t y, input logic s);
		logic [DATA_WIDTH:0] wide;
		result_t r;
		if (s) begin
			wide = {1'b0, x} - {1'b0, y};
		end else begin
			wide = {1'b0, x} + {1'b0, y};
		end
		r.sum = wide[DATA_WIDTH-1:0];
		// A borrow sets the top bit of the difference, carry is its inverse
		r.carry = s ? !wide[DATA_WIDTH] : wide[DATA_WIDTH];
		if (s) begin
			r.overflow = (x[DATA_WIDTH-1] != y[DATA_WIDTH-1]) &&
				(r.sum[DATA_WIDTH-1] != x[DATA_WIDTH-1]);
		end else begin
			r.overflow = (x[DATA_WIDTH-1] == y[DATA_WIDTH-1]) &&
				(r.sum[DATA_WIDTH-1] != x[DATA_WIDTH-1]);
		end
		r.zero = (r.sum == '0);
		r.negative = r.sum[DATA_WIDTH-1];
		return r;
	endfunction

	task automatic check_field(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	always @(posedge clk) begin
		cycle++;
		if (!rst && in_valid) begin
			exp_q.push_back('{res: ref_add(a, b, sub), cycle: cycle});
			n_pushed++;
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			if ($isunknown(out_valid)) begin
				n_errors++;
				$display("out_valid is unknown at cycle %0d", cycle);
			end else if (out_valid) begin
				if (exp_q.size() == 0) begin
					n_errors++;
					$display("result strobe at cycle %0d with no operation pending", cycle);
				end else begin
					item = exp_q.pop_front();
					n_popped++;
					if (cycle - item.cycle != DUE_CYCLES) begin
						n_errors++;
						$display("result came %0d cycles after its operation instead of %0d",
							cycle - item.cycle, DUE_CYCLES);
					end
					check_field("sum", result.sum, item.res.sum);
					check_field("carry", result.carry, item.res.carry);
					check_field("overflow", result.overflow, item.res.overflow);
					check_field("zero", result.zero, item.res.zero);
					check_field("negative", result.negative, item.res.negative);
				end
			end else if (exp_q.size() != 0 && cycle - exp_q[0].cycle >= DUE_CYCLES) begin
				item = exp_q.pop_front();
				n_popped++;
				n_errors++;
				$display("no result strobe for the operation taken at cycle %0d", item.cycle);
			end
		end
	end

endmodule

//--- sim/add_unit_tb.sv
// Inputs change only on the falling edge; random operands come from a 16-bit LFSR seeded with 57
module add_unit_tb;

	import adder_pkg::*;

	localparam int RESET_CYCLES = 2;
	localparam int N_RANDOM = 200;
	localparam int N_GAPPED = 100;
	localparam int MAX_GAP = 3;
	localparam int DIRECTED_CYCLES = 9 + 3 + 4 + 3;
	localparam int DRAIN_CYCLES = 8;
	localparam int NUM_TESTS = 6;
	// Upper bound on the length of all tests
	localparam int STIM_CYCLES = RESET_CYCLES + 1 + DIRECTED_CYCLES + N_RANDOM +
		N_GAPPED * (1 + MAX_GAP) + NUM_TESTS * DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = STIM_CYCLES + 20;

	logic clk = 1'b0;
	logic rst;
	word_t a;
	word_t b;
	logic sub;
	logic in_valid;
	result_t result;
	logic out_valid;
	int pushed;
	int popped;
	int errors;
	logic [15:0] lfsr = 16'd57;
	int cycle_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int ops_in_test = 0;
	int errors_before = 0;

	always #20 clk = ~clk;

	add_unit_top #(
		.WIDTH(DATA_WIDTH),
		.SLICE_WIDTH(SLICE_WIDTH_DEFAULT)
	) DUT (
		.clk(clk),
		.rst(rst),
		.a(a),
		.b(b),
		.sub(sub),
		.in_valid(in_valid),
		.result(result),
		.out_valid(out_valid)
	);

	add_unit_checker u_checker (
		.clk(clk),
		.rst(rst),
		.a(a),
		.b(b),
		.sub(sub),
		.in_valid(in_valid),
		.result(result),
		.out_valid(out_valid),
		.pushed(pushed),
		.popped(popped),
		.errors(errors)
	);

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[DATA_WIDTH-2:0], lfsr[0]};
		end
	endtask

	// Entered on a falling edge, returns on the next one
	task automatic issue(input word_t x, input word_t y, input logic s);
		in_valid = 1'b1;
		a = x;
		b = y;
		sub = s;
		ops_in_test++;
		@(negedge clk);
	endtask

	task automatic idle(input int n);
		in_valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic finish_test(input string name);
		int delta;
		idle(1);
		do @(posedge clk); while (popped != pushed);
		// Stray strobes would show up here
		repeat (2) @(negedge clk);
		@(posedge clk);
		delta = errors - errors_before;
		errors_before = errors;
		tests_run++;
		if (delta != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %0d operations, %0d errors", tests_run, name, ops_in_test, delta);
		ops_in_test = 0;
		@(negedge clk);
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with results still missing", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		word_t x;
		word_t y;
		word_t s;
		word_t gap;
		rst = 1'b1;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		sub = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		idle(4);
		issue(64'd1, 64'd2, 1'b0);
		idle(3);
		issue(64'd10, 64'd3, 1'b1);
		finish_test("reset and strobe timing");

		issue('0, '0, 1'b0);
		issue('1, 64'd1, 1'b0);
		issue(64'h7fff_ffff_ffff_ffff, 64'd1, 1'b0);
		finish_test("directed additions");

		// Low half all ones, so the high half depends on the low carry out
		issue({32'h0000_0000, 32'hffff_ffff}, 64'd1, 1'b0);
		issue({32'h1234_5678, 32'hffff_ffff}, 64'd1, 1'b0);
		issue({32'h7fff_ffff, 32'hffff_ffff}, 64'd1, 1'b0);
		issue({32'hffff_fffe, 32'hffff_ffff}, 64'h0000_0001_0000_0001, 1'b0);
		finish_test("carry across the slice boundary");

		issue(64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef, 1'b1);
		issue(64'd5, 64'd9, 1'b1);
		issue(64'h8000_0000_0000_0000, 64'd1, 1'b1);
		finish_test("directed subtractions");

		for (int i = 0; i < N_RANDOM; i++) begin
			take_bits(DATA_WIDTH, x);
			take_bits(DATA_WIDTH, y);
			take_bits(1, s);
			issue(x, y, s[0]);
		end
		finish_test("random back to back");

		for (int i = 0; i < N_GAPPED; i++) begin
			take_bits(DATA_WIDTH, x);
			take_bits(DATA_WIDTH, y);
			take_bits(1, s);
			take_bits(2, gap);
			issue(x, y, s[0]);
			idle(int'(gap));
		end
		finish_test("random with idle gaps");

		if (pushed != popped) begin
			$display("%0d operations were left without a result", pushed - popped);
		end
		$display("summary: %0d tests, %0d with errors, %0d operations, %0d errors",
			tests_run, tests_failed, pushed, errors);
		if (tests_failed == 0 && errors == 0 && pushed == popped) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
source/adder_pkg.sv
source/operand_stage.sv
source/prefix_tree.sv
source/prefix_adder_slice.sv
source/result_combine.sv
source/add_unit_top.sv
sim/add_unit_checker.sv
sim/add_unit_tb.sv

//--- Bender.yml
package:
  name: add_unit

sources:
  - source/adder_pkg.sv
  - source/operand_stage.sv
  - source/prefix_tree.sv
  - source/prefix_adder_slice.sv
  - source/result_combine.sv
  - source/add_unit_top.sv
  - target: simulation
    files:
      - sim/add_unit_checker.sv
      - sim/add_unit_tb.sv
